// File: csb_seq_pkg.sv
package csb_seq_pkg;

   // Bus widths
   localparam int CSB_DATA_W = 32;
   localparam int CSB_ADDR_W = 22;

   // Command field widths
   localparam int OP_W       = 4;
   localparam int CMP_W      = 2;
   localparam int FLAG_W     = 8;
   localparam int REG_ADDR_W = 16;

   // 64 command lines
   localparam int CMD_ADDR_W = 6;

   // Status and internal counters
   localparam int FAIL_CNT_W = 8;
   localparam int TIMER_W    = 16;

   // Command opcodes
   typedef enum logic [OP_W-1:0] {
      op_done      = 4'h0,
      op_reg_read  = 4'h1,
      op_reg_write = 4'h2,
      op_wait      = 4'h3
   } seq_op_e;

   // How read data is tested against the command data
   typedef enum logic [CMP_W-1:0] {
      cmp_eq = 2'h0,
      cmp_le = 2'h1,
      cmp_ge = 2'h2
   } cmp_mode_e;

   // One command line, 62 bits
   typedef struct packed {
      seq_op_e               op;
      cmp_mode_e             cmp;
      logic [FLAG_W-1:0]     pd_flags;
      logic [REG_ADDR_W-1:0] addr;
      logic [CSB_DATA_W-1:0] data;
   } seq_cmd_t;

   // CSB request packet, 63 bits
   // Flags on top, then the write bit, write data and word address
   typedef struct packed {
      logic [FLAG_W-1:0]     flags;
      logic                  write;
      logic [CSB_DATA_W-1:0] wdat;
      logic [CSB_ADDR_W-1:0] addr;
   } csb_req_t;

   // Sequencer status seen by the testbench
   typedef struct packed {
      logic                  done;
      logic [FAIL_CNT_W-1:0] fail_count;
   } seq_status_t;

endpackage

// File: cmd_store.sv
`timescale 1ns/1ns

module cmd_store (
   input  logic                                clk,
   input  logic                                cmd_load,
   input  logic [csb_seq_pkg::CMD_ADDR_W-1:0]  cmd_load_addr,
   input  csb_seq_pkg::seq_cmd_t               cmd_load_data,
   input  logic [csb_seq_pkg::CMD_ADDR_W-1:0]  line,
   output csb_seq_pkg::seq_cmd_t               cur_cmd
);

   import csb_seq_pkg::*;

   localparam int DEPTH = 2 ** CMD_ADDR_W;

   // Command list
   seq_cmd_t mem [0:DEPTH-1];

   // Load port
   // Only used while the sequencer sits in reset or boot,
   // so there is no conflict with the fetch read below
   always_ff @(posedge clk) begin
      if (cmd_load) begin
         mem[cmd_load_addr] <= cmd_load_data;
      end
   end

   // Fetch stage
   // The line pointer stays put for the whole command,
   // so cur_cmd is stable from dispatch until the next fetch
   always_ff @(posedge clk) begin
      cur_cmd <= mem[line];
   end

endmodule

// File: seq_control.sv
`timescale 1ns/1ns

module seq_control #(
   parameter int unsigned BOOT_CYCLES   = 8,
   parameter int unsigned POLL_INTERVAL = 4,
   parameter int unsigned MAX_POLLS     = 3,
   parameter int unsigned RD_TIMEOUT    = 20,
   parameter int unsigned WR_TIMEOUT    = 20,
   parameter int unsigned WAIT_TIMEOUT  = 40
) (
   input  logic                                clk,
   input  logic                                reset,
   input  csb_seq_pkg::seq_cmd_t               cur_cmd,
   input  logic                                rvalid,
   input  logic                                hit,
   input  logic                                intr,
   input  logic                                continue_on_fail,
   output logic [csb_seq_pkg::CMD_ADDR_W-1:0]  line,
   output logic                                issue,
   output logic                                fetch,
   output csb_seq_pkg::seq_status_t            status
);

   import csb_seq_pkg::*;

   localparam int POLL_W = $clog2(MAX_POLLS + 1) + 1;

   typedef enum logic [3:0] {
      st_boot,
      st_fetch,
      st_dispatch,
      st_issue,
      st_wait_resp,
      st_poll_wait,
      st_wait_intr,
      st_fail,
      st_done
   } state_e;

   state_e                  state;
   state_e                  state_next;
   logic [TIMER_W-1:0]      timer;
   logic [TIMER_W-1:0]      resp_limit;
   logic [POLL_W-1:0]       poll_cnt;
   logic [FAIL_CNT_W-1:0]   fail_count;
   logic                    is_read;
   logic                    advance;

   assign is_read    = (cur_cmd.op == op_reg_read);
   assign resp_limit = is_read ? TIMER_W'(RD_TIMEOUT) : TIMER_W'(WR_TIMEOUT);

   always_comb begin
      state_next = state;
      case (state)
         st_boot: begin
            if (timer >= TIMER_W'(BOOT_CYCLES)) begin
               state_next = st_fetch;
            end
         end
         st_fetch: begin
            state_next = st_dispatch;
         end
         st_dispatch: begin
            // op_done and any unknown opcode end the run
            case (cur_cmd.op)
               op_reg_read,
               op_reg_write: state_next = st_issue;
               op_wait:      state_next = st_wait_intr;
               default:      state_next = st_done;
            endcase
         end
         st_issue: begin
            state_next = st_wait_resp;
         end
         st_wait_resp: begin
            if (rvalid) begin
               // Any response completes a write
               if (!is_read || hit) begin
                  state_next = st_fetch;
               end else if (poll_cnt == POLL_W'(MAX_POLLS)) begin
                  state_next = st_fail;
               end else begin
                  state_next = st_poll_wait;
               end
            end else if (timer > resp_limit) begin
               state_next = st_fail;
            end
         end
         st_poll_wait: begin
            // Leave one cycle early so the retry strobe lands on time
            if ((timer + 1'b1) >= TIMER_W'(POLL_INTERVAL)) begin
               state_next = st_issue;
            end
         end
         st_wait_intr: begin
            if (intr) begin
               state_next = st_fetch;
            end else if (timer > TIMER_W'(WAIT_TIMEOUT)) begin
               state_next = st_fail;
            end
         end
         st_fail: begin
            state_next = continue_on_fail ? st_fetch : st_done;
         end
         st_done: begin
            state_next = st_done;
         end
         default: begin
            state_next = st_done;
         end
      endcase
   end

   // Step to the next line whenever a command is finished with
   assign advance = (state_next == st_fetch) && (state != st_boot);

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state      <= st_boot;
         line       <= '0;
         timer      <= '0;
         poll_cnt   <= '0;
         fail_count <= '0;
      end else begin
         state <= state_next;

         if (advance) begin
            line <= line + 1'b1;
         end

         // Shared timer restarts on every state change
         if (state_next != state) begin
            timer <= '0;
         end else if (state != st_done) begin
            timer <= timer + 1'b1;
         end

         // Attempts of the current read
         if (state == st_dispatch) begin
            poll_cnt <= '0;
         end else if (state == st_wait_resp && state_next == st_poll_wait) begin
            poll_cnt <= poll_cnt + 1'b1;
         end

         // Saturating failure count
         if (state == st_fail && fail_count != '1) begin
            fail_count <= fail_count + 1'b1;
         end
      end
   end

   assign issue             = (state == st_issue);
   assign fetch             = (state == st_fetch);
   assign status.done       = (state == st_done);
   assign status.fail_count = fail_count;

endmodule

// File: req_build.sv
`timescale 1ns/1ns

module req_build (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   issue,
   input  logic                   fetch,
   input  csb_seq_pkg::seq_cmd_t  cur_cmd,
   output logic                   req_pending,
   output csb_seq_pkg::csb_req_t  req_pd
);

   import csb_seq_pkg::*;

   csb_req_t pd_next;

   // Packet fields from the current command
   always_comb begin
      pd_next.flags = cur_cmd.pd_flags;
      pd_next.write = (cur_cmd.op == op_reg_write);
      // Reads carry the command data too, the bus ignores it
      pd_next.wdat  = cur_cmd.data;
      pd_next.addr  = {{(CSB_ADDR_W - REG_ADDR_W){1'b0}}, cur_cmd.addr};
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         req_pending <= 1'b0;
         req_pd      <= '0;
      end else begin
         // Strobe lasts exactly the cycle after issue
         req_pending <= issue;
         if (issue) begin
            req_pd <= pd_next;
         end else if (fetch) begin
            req_pd <= '0;
         end
      end
   end

endmodule

// File: resp_check.sv
`timescale 1ns/1ns

module resp_check (
   input  logic [csb_seq_pkg::CSB_DATA_W-1:0]  rdata,
   input  csb_seq_pkg::seq_cmd_t               cur_cmd,
   output logic                                hit
);

   import csb_seq_pkg::*;

   logic [CSB_DATA_W-1:0] rdata_clean;

   // X and Z bits read as zero
   always_comb begin
      for (int i = 0; i < CSB_DATA_W; i++) begin
         if (rdata[i]) begin
            rdata_clean[i] = 1'b1;
         end else begin
            rdata_clean[i] = 1'b0;
         end
      end
   end

   // Unsigned compare against the expected value
   always_comb begin
      case (cur_cmd.cmp)
         cmp_eq:  hit = (rdata_clean == cur_cmd.data);
         cmp_le:  hit = (rdata_clean <= cur_cmd.data);
         cmp_ge:  hit = (rdata_clean >= cur_cmd.data);
         default: hit = 1'b0;
      endcase
   end

endmodule

// File: csb_master_seq.sv
`timescale 1ns/1ns

module csb_master_seq #(
   parameter int unsigned BOOT_CYCLES   = 8,
   parameter int unsigned POLL_INTERVAL = 4,
   parameter int unsigned MAX_POLLS     = 3,
   parameter int unsigned RD_TIMEOUT    = 20,
   parameter int unsigned WR_TIMEOUT    = 20,
   parameter int unsigned WAIT_TIMEOUT  = 40
) (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                cmd_load,
   input  logic [csb_seq_pkg::CMD_ADDR_W-1:0]  cmd_load_addr,
   input  csb_seq_pkg::seq_cmd_t               cmd_load_data,
   input  logic                                continue_on_fail,
   output logic                                req_pending,
   output csb_seq_pkg::csb_req_t               req_pd,
   input  logic                                rvalid,
   input  logic [csb_seq_pkg::CSB_DATA_W-1:0]  rdata,
   input  logic                                intr,
   output csb_seq_pkg::seq_status_t            status
);

   import csb_seq_pkg::*;

   logic [CMD_ADDR_W-1:0] line;
   seq_cmd_t              cur_cmd;
   logic                  issue;
   logic                  fetch;
   logic                  hit;

   cmd_store i_cmd_store (
      .clk           (clk),
      .cmd_load      (cmd_load),
      .cmd_load_addr (cmd_load_addr),
      .cmd_load_data (cmd_load_data),
      .line          (line),
      .cur_cmd       (cur_cmd)
   );

   seq_control #(
      .BOOT_CYCLES   (BOOT_CYCLES),
      .POLL_INTERVAL (POLL_INTERVAL),
      .MAX_POLLS     (MAX_POLLS),
      .RD_TIMEOUT    (RD_TIMEOUT),
      .WR_TIMEOUT    (WR_TIMEOUT),
      .WAIT_TIMEOUT  (WAIT_TIMEOUT)
   ) i_seq_control (
      .clk              (clk),
      .reset            (reset),
      .cur_cmd          (cur_cmd),
      .rvalid           (rvalid),
      .hit              (hit),
      .intr             (intr),
      .continue_on_fail (continue_on_fail),
      .line             (line),
      .issue            (issue),
      .fetch            (fetch),
      .status           (status)
   );

   req_build i_req_build (
      .clk         (clk),
      .reset       (reset),
      .issue       (issue),
      .fetch       (fetch),
      .cur_cmd     (cur_cmd),
      .req_pending (req_pending),
      .req_pd      (req_pd)
   );

   // Only sampled by the FSM while rvalid is high
   resp_check i_resp_check (
      .rdata   (rdata),
      .cur_cmd (cur_cmd),
      .hit     (hit)
   );

endmodule

// File: csb_seq_props.sv
`timescale 1ns/1ns

module csb_seq_props (
   input logic clk,
   input logic reset,
   input logic strobe,
   input logic done
);

   // Bus request strobe lasts a single cycle
   a_strobe_one_cycle: assert property (
      @(posedge clk) disable iff (!reset) strobe |=> !strobe
   ) else $error("request strobe held for two cycles");

   // No new request once the run has ended
   a_no_strobe_in_done: assert property (
      @(posedge clk) disable iff (!reset) done |-> !strobe
   ) else $error("request strobe while done is high");

   a_done_sticky: assert property (
      @(posedge clk) disable iff (!reset) done |=> done
   ) else $error("done dropped before reset");

endmodule

// File: csb_master_seq_tb.sv
`timescale 1ns/1ns

module csb_master_seq_tb;

   import csb_seq_pkg::*;

   localparam int BOOT_CYCLES   = 8;
   localparam int POLL_INTERVAL = 4;
   localparam int MAX_POLLS     = 3;
   localparam int RD_TIMEOUT    = 20;
   localparam int WR_TIMEOUT    = 20;
   localparam int WAIT_TIMEOUT  = 40;

   // Pattern columns, one row per command
   localparam int NCOL     = 14;
   localparam int MAX_ROWS = 64;
   localparam int C_TEST   = 0;
   localparam int C_COF    = 1;
   localparam int C_OP     = 2;
   localparam int C_CMP    = 3;
   localparam int C_FLAGS  = 4;
   localparam int C_ADDR   = 5;
   localparam int C_DATA   = 6;
   localparam int C_MODE   = 7;
   localparam int C_DELAY  = 8;
   localparam int C_RD0    = 9;
   localparam int C_EXP    = 13;

   logic                  clk;
   logic                  reset;
   logic                  cmd_load;
   logic [CMD_ADDR_W-1:0] cmd_load_addr;
   seq_cmd_t              cmd_load_data;
   logic                  continue_on_fail;
   logic                  req_pending;
   csb_req_t              req_pd;
   logic                  rvalid;
   logic [CSB_DATA_W-1:0] rdata;
   logic                  intr;
   seq_status_t           status;

   logic [31:0] pat [0:MAX_ROWS*NCOL-1];
   integer      seed;
   int          nrows;
   int          errors;
   int          checks;
   int          req_count;
   int          exp_reqs;
   int          cycle_count;
   int          limit;

   csb_master_seq #(
      .BOOT_CYCLES   (BOOT_CYCLES),
      .POLL_INTERVAL (POLL_INTERVAL),
      .MAX_POLLS     (MAX_POLLS),
      .RD_TIMEOUT    (RD_TIMEOUT),
      .WR_TIMEOUT    (WR_TIMEOUT),
      .WAIT_TIMEOUT  (WAIT_TIMEOUT)
   ) i_dut (
      .clk              (clk),
      .reset            (reset),
      .cmd_load         (cmd_load),
      .cmd_load_addr    (cmd_load_addr),
      .cmd_load_data    (cmd_load_data),
      .continue_on_fail (continue_on_fail),
      .req_pending      (req_pending),
      .req_pd           (req_pd),
      .rvalid           (rvalid),
      .rdata            (rdata),
      .intr             (intr),
      .status           (status)
   );

   bind csb_master_seq csb_seq_props i_props (
      .clk    (clk),
      .reset  (reset),
      .strobe (req_pending),
      .done   (status.done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) cycle_count <= cycle_count + 1;

   // Bus side view of every request strobe
   always @(negedge clk) begin
      if (req_pending) begin
         req_count <= req_count + 1;
      end
   end

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      end
   endtask

   // Read data compare as the command's mode defines it
   function automatic bit compare_hit(input logic [1:0] mode, input logic [31:0] got,
                                      input logic [31:0] want);
      case (mode)
         2'd0:    return got == want;
         2'd1:    return got <= want;
         2'd2:    return got >= want;
         default: return 1'b0;
      endcase
   endfunction

   function automatic int pick_delay(input logic [31:0] d);
      if (d != 0) begin
         return d;
      end
      return 1 + (($random(seed) & 32'h7fffffff) % 5);
   endfunction

   function automatic seq_cmd_t row_cmd(input int r);
      seq_cmd_t cmd;
      cmd.op       = seq_op_e'(pat[r*NCOL+C_OP][3:0]);
      cmd.cmp      = cmp_mode_e'(pat[r*NCOL+C_CMP][1:0]);
      cmd.pd_flags = pat[r*NCOL+C_FLAGS][7:0];
      cmd.addr     = pat[r*NCOL+C_ADDR][15:0];
      cmd.data     = pat[r*NCOL+C_DATA];
      return cmd;
   endfunction

   // Next request strobe or done, counted in cycles
   task automatic wait_event(output bit got_req, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!req_pending && !status.done);
      got_req = req_pending;
   endtask

   task automatic respond(input int delay, input logic [31:0] data);
      repeat (delay) @(negedge clk);
      rvalid = 1'b1;
      rdata  = data;
      @(negedge clk);
      rvalid = 1'b0;
      rdata  = '0;
   endtask

   task automatic check_request(input int base, input bit write);
      exp_reqs++;
      check("req_pd.flags", pat[base+C_FLAGS][7:0], req_pd.flags);
      check("req_pd.write", write, req_pd.write);
      check("req_pd.wdat", pat[base+C_DATA], req_pd.wdat);
      check("req_pd.addr", {6'h0, pat[base+C_ADDR][15:0]}, req_pd.addr);
   endtask

   task automatic run_row(input int r, input bit cof, output bit stop);
      int         base;
      logic [3:0] op;
      int         delay;
      int         attempt;
      int         cycles;
      bit         got;
      bit         finished;
      base     = r * NCOL;
      op       = pat[base+C_OP][3:0];
      delay    = pick_delay(pat[base+C_DELAY]);
      stop     = 1'b0;
      attempt  = 0;
      finished = 0;
      if (op == op_wait) begin
         if (pat[base+C_MODE] == 0) begin
            // Level held until the next command shows up
            repeat (delay) @(negedge clk);
            intr = 1'b1;
         end else begin
            stop = !cof;
         end
      end else if (op == op_reg_read || op == op_reg_write) begin
         while (!finished) begin
            wait_event(got, cycles);
            intr = 1'b0;
            if (!got) begin
               errors++;
               $display("done raised at %0t while row %0d still expected a request", $time, r);
               stop     = 1'b1;
               finished = 1;
            end else begin
               if (attempt > 0) begin
                  check("retry gap", POLL_INTERVAL + 2, cycles + 1);
               end
               check_request(base, op == op_reg_write);
               if (pat[base+C_MODE] != 0) begin
                  stop     = !cof;
                  finished = 1;
               end else begin
                  respond(delay, pat[base+C_RD0+attempt]);
                  if (op == op_reg_write ||
                      compare_hit(pat[base+C_CMP][1:0], pat[base+C_RD0+attempt],
                                  pat[base+C_DATA])) begin
                     finished = 1;
                  end else if (attempt == MAX_POLLS) begin
                     stop     = !cof;
                     finished = 1;
                  end else begin
                     attempt++;
                  end
               end
            end
         end
      end else begin
         wait_event(got, cycles);
         intr = 1'b0;
         if (got) begin
            errors++;
            $display("request at %0t where row %0d expected done", $time, r);
         end
         stop = 1'b1;
      end
   endtask

   task automatic run_test(input int first, input int n);
      bit          cof;
      bit          stop;
      logic [31:0] exp_fail;
      cof      = pat[first*NCOL+C_COF][0];
      exp_fail = pat[first*NCOL+C_EXP];
      stop     = 1'b0;
      @(negedge clk);
      reset            = 1'b0;
      continue_on_fail = cof;
      req_count        = 0;
      exp_reqs         = 0;
      // Commands go in during reset and the first boot cycles
      for (int k = 0; k < n; k++) begin
         if (k == 2) begin
            reset = 1'b1;
         end
         cmd_load      = 1'b1;
         cmd_load_addr = k;
         cmd_load_data = row_cmd(first + k);
         @(negedge clk);
      end
      cmd_load = 1'b0;
      reset    = 1'b1;
      for (int k = 0; k < n && !stop; k++) begin
         run_row(first + k, cof, stop);
      end
      while (!status.done) @(negedge clk);
      intr = 1'b0;
      // Quiet window, no strobe may follow done
      repeat (10) @(negedge clk);
      check("status.done", 1, status.done);
      check("status.fail_count", exp_fail, status.fail_count);
      check("request count", exp_reqs, req_count);
      $display("test %0d finished at %0t", pat[first*NCOL+C_TEST], $time);
   endtask

   initial begin
      int r;
      int first;
      reset            = 1'b0;
      cmd_load         = 1'b0;
      cmd_load_addr    = '0;
      cmd_load_data    = '0;
      continue_on_fail = 1'b0;
      rvalid           = 1'b0;
      rdata            = '0;
      intr             = 1'b0;
      seed             = 60670;
      errors           = 0;
      checks           = 0;
      cycle_count      = 0;
      limit            = 0;
      nrows            = 0;
      $readmemh("csb_seq_patterns.txt", pat);
      while (nrows < MAX_ROWS && !$isunknown(pat[nrows*NCOL])) begin
         nrows++;
      end
      // Worst case of every command plus load and boot, doubled
      for (int i = 0; i < nrows; i++) begin
         case (pat[i*NCOL+C_OP][3:0])
            4'h1:    limit += (MAX_POLLS + 1) * (RD_TIMEOUT + POLL_INTERVAL + 8);
            4'h2:    limit += WR_TIMEOUT + 8;
            4'h3:    limit += WAIT_TIMEOUT + 8;
            default: limit += BOOT_CYCLES + 30;
         endcase
      end
      limit = 2 * (limit + BOOT_CYCLES + 30);
      if (nrows == 0) begin
         errors++;
         $display("no command rows could be read from the pattern file");
      end
      r = 0;
      while (r < nrows) begin
         first = r;
         while (r < nrows && pat[r*NCOL+C_TEST] == pat[first*NCOL+C_TEST]) begin
            r++;
         end
         run_test(first, r - first);
      end
      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      wait (limit > 0 && cycle_count > limit);
      $display("run timed out after %0d cycles without finishing all tests", cycle_count);
      $display("errors: %0d of %0d checks", errors, checks);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: csb_seq_patterns.txt
// test cof op cmp flags addr data mode delay rd0 rd1 rd2 rd3 exp_fail (all hex)
// op 0 done 1 read 2 write 3 wait, cmp 0 eq 1 le 2 ge, mode 0 answer 1 silent, delay 0 random
1 1 2 0 5a 1234 deadbeef 0 2 00000000 00000000 00000000 00000000 0
1 1 2 0 01 ffff 00000001 0 0 00000000 00000000 00000000 00000000 0
1 1 1 0 c3 0010 cafe0001 0 3 cafe0001 00000000 00000000 00000000 0
1 1 1 1 00 0020 00000100 0 0 000000ff 00000000 00000000 00000000 0
1 1 1 2 80 0030 00000100 0 1 00000200 00000000 00000000 00000000 0
1 1 0 0 00 0000 00000000 0 0 00000000 00000000 00000000 00000000 0
2 1 1 0 11 0040 00000055 0 2 00000000 00000001 00000002 00000003 1
2 1 1 2 22 0041 00000080 0 0 00000010 00000020 00000090 00000000 1
2 1 2 0 33 0042 12345678 0 1 00000000 00000000 00000000 00000000 1
2 1 0 0 00 0000 00000000 0 0 00000000 00000000 00000000 00000000 1
3 1 1 0 44 0050 00000001 1 0 00000000 00000000 00000000 00000000 3
3 1 2 0 45 0051 0000abcd 1 0 00000000 00000000 00000000 00000000 3
3 1 3 0 00 0000 00000000 1 0 00000000 00000000 00000000 00000000 3
3 1 2 0 46 0052 00000002 0 0 00000000 00000000 00000000 00000000 3
3 1 3 0 00 0000 00000000 0 4 00000000 00000000 00000000 00000000 3
3 1 1 1 47 0053 00000010 0 0 00000008 00000000 00000000 00000000 3
3 1 0 0 00 0000 00000000 0 0 00000000 00000000 00000000 00000000 3
4 0 2 0 50 0060 00000005 0 0 00000000 00000000 00000000 00000000 1
4 0 1 0 51 0061 00000077 0 0 00000001 00000002 00000003 00000004 1
4 0 2 0 52 0062 00000009 0 0 00000000 00000000 00000000 00000000 1
4 0 0 0 00 0000 00000000 0 0 00000000 00000000 00000000 00000000 1

// File: verilog.f
csb_seq_pkg.sv
cmd_store.sv
seq_control.sv
req_build.sv
resp_check.sv
csb_master_seq.sv
csb_seq_props.sv
csb_master_seq_tb.sv
